/* files.f */
+incdir+verilog
verilog/uop_pkg.sv
verilog/cdb_pkg.sv
verilog/dispatch_router.sv
verilog/issue_queue.sv
verilog/int_fu.sv
verilog/phys_regfile.sv
verilog/cdb_arbiter.sv
verilog/exec_cluster.sv
tb/cdb_checker.sv
tb/exec_cluster_tb.sv

/* tb/exec_cluster_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module exec_cluster_tb;

    import uop_pkg::*;
    import cdb_pkg::*;

    localparam int MAX_ROWS = 48;

    typedef enum logic [1:0] {
        ROW_WRITE,
        ROW_UOP,
        ROW_DRAIN
    } row_kind_e;

    // one stimulus step
    typedef struct packed {
        row_kind_e              kind;
        logic [127:0]           name;
        uop_t                   uop;
        logic [`PRF_IDX-1:0]    wb_phy;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    uop_t                   in_uop;
    logic                   in_ready;
    logic                   wb_valid;
    logic [`PRF_IDX-1:0]    wb_phy;
    logic [`XLEN-1:0]       wb_value;
    logic                   cdb_valid;
    cdb_t                   cdb;
    logic [127:0]           test_name;
    logic                   finish_run;
    int                     pass_count;
    int                     err_count;
    int                     outstanding;

    row_t   stim [MAX_ROWS];
    int     num_rows;
    int     cycle_count;
    int     cycle_limit;
    int     seed;

    exec_cluster DUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .wb_valid   (wb_valid),
        .wb_phy     (wb_phy),
        .wb_value   (wb_value),
        .in_ready   (in_ready),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb)
    );

    cdb_checker u_cdb_check (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_uop      (in_uop),
        .test_name   (test_name),
        .wb_valid    (wb_valid),
        .wb_phy      (wb_phy),
        .wb_value    (wb_value),
        .cdb_valid   (cdb_valid),
        .cdb         (cdb),
        .finish_run  (finish_run),
        .pass_count  (pass_count),
        .err_count   (err_count),
        .outstanding (outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // table construction
    // ------------------------------

    task automatic add_write(input logic [127:0] name, input int phy);
        row_t r;
        r        = '0;
        r.kind   = ROW_WRITE;
        r.name   = name;
        r.wb_phy = phy[`PRF_IDX-1:0];
        stim[num_rows] = r;
        num_rows++;
    endtask

    task automatic add_uop(input logic [127:0] name, input int rob, input fu_op_e op,
                           input int rd, input int rs1, input logic rdy1,
                           input int rs2, input logic rdy2);
        row_t r;
        r               = '0;
        r.kind          = ROW_UOP;
        r.name          = name;
        r.uop.rob_id    = rob[`ROB_IDX-1:0];
        r.uop.rd_phy    = rd[`PRF_IDX-1:0];
        r.uop.rs1_phy   = rs1[`PRF_IDX-1:0];
        r.uop.rs1_ready = rdy1;
        r.uop.rs2_phy   = rs2[`PRF_IDX-1:0];
        r.uop.rs2_ready = rdy2;
        r.uop.op        = op;
        stim[num_rows]  = r;
        num_rows++;
    endtask

    task automatic add_drain();
        row_t r;
        r      = '0;
        r.kind = ROW_DRAIN;
        stim[num_rows] = r;
        num_rows++;
    endtask

    task automatic build_table();
        // every operation on two loaded registers
        add_write("load_r1", 1);
        add_write("load_r2", 2);
        for (int i = 0; i < 8; i++) begin
            add_uop({"op_", 8'(8'h30 + i)}, i, fu_op_e'(i), 10 + i, 1, 1'b1, 2, 1'b1);
        end
        add_drain();
        // dependent chain through the internal CDB
        add_uop("chain_head", 8, FU_ADD, 20, 1, 1'b1, 2, 1'b1);
        add_uop("chain_mul", 9, FU_MUL, 21, 20, 1'b0, 2, 1'b1);
        add_uop("chain_sub", 10, FU_SUB, 22, 21, 1'b0, 1, 1'b1);
        add_drain();
        // wakeup from the external writeback
        add_uop("wake_or", 11, FU_OR, 23, 30, 1'b0, 2, 1'b1);
        add_uop("wake_sll", 12, FU_SLL, 24, 1, 1'b1, 31, 1'b0);
        add_write("load_r30", 30);
        add_write("load_r31", 31);
        add_drain();
        // eight waiters fill both lanes
        for (int i = 0; i < 8; i++) begin
            add_uop({"burst_", 8'(8'h30 + i)}, 13 + i, fu_op_e'(i), 40 + i, 32, 1'b0,
                    10 + i, 1'b1);
        end
        add_write("load_r32", 32);
        add_drain();
        add_uop("after_burst", 21, FU_ADD, 50, 40, 1'b1, 47, 1'b1);
        add_drain();
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    task automatic apply_row(input row_t r);
        case (r.kind)
            ROW_WRITE: begin
                wb_valid = 1'b1;
                wb_phy   = r.wb_phy;
                wb_value = $random(seed);
                @(posedge clk);
                #1;
                wb_valid = 1'b0;
            end
            ROW_UOP: begin
                test_name = r.name;
                in_uop    = r.uop;
                in_valid  = 1'b1;
                @(posedge clk);
                while (!in_ready) begin
                    @(posedge clk);
                end
                #1;
                in_valid = 1'b0;
            end
            default: begin
                while (outstanding != 0) begin
                    @(posedge clk);
                    #1;
                end
            end
        endcase
    endtask

    task automatic close_run(input logic timed_out);
        finish_run = 1'b1;
        #1;
        $display("results ok %0d, errors %0d", pass_count, err_count);
        if (!timed_out && (err_count == 0)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        seed       = 32'h5435;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_uop     = '0;
        wb_valid   = 1'b0;
        wb_phy     = '0;
        wb_value   = '0;
        test_name  = '0;
        finish_run = 1'b0;
        num_rows   = 0;
        build_table();
        cycle_limit = num_rows * 20 + 200;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            apply_row(stim[i]);
        end
        close_run(1'b0);
    end

    // watchdog, limit scales with the table
    initial begin
        cycle_count = 0;
        #1;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d results still outstanding",
                 cycle_count, outstanding);
        close_run(1'b1);
    end

endmodule

`default_nettype wire

/* tb/cdb_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module cdb_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  logic                    in_ready,
    input  uop_pkg::uop_t           in_uop,
    input  logic [127:0]            test_name,
    input  logic                    wb_valid,
    input  logic [`PRF_IDX-1:0]     wb_phy,
    input  logic [`XLEN-1:0]        wb_value,
    input  logic                    cdb_valid,
    input  cdb_pkg::cdb_t           cdb,
    input  logic                    finish_run,
    output int                      pass_count,
    output int                      err_count,
    output int                      outstanding
);

    import uop_pkg::*;
    import cdb_pkg::*;

    localparam int ROB_N = 1 << `ROB_IDX;

    // register values as the program order defines them
    logic [`XLEN-1:0]   model_val   [`PRF_DEPTH];
    logic               model_known [`PRF_DEPTH];

    // micro-ops in flight by rob_id
    logic               pend     [ROB_N];
    uop_t               rec      [ROB_N];
    logic [127:0]       rec_name [ROB_N];

    logic               seen_reset;
    logic               reset_checked;
    logic               saw_full;

    function automatic logic [`XLEN-1:0] apply_op(
        input fu_op_e           op,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        logic [2*`XLEN-1:0] prod;
        prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        case (op)
            FU_ADD:  return a + b;
            FU_SUB:  return a - b;
            FU_AND:  return a & b;
            FU_OR:   return a | b;
            FU_XOR:  return a ^ b;
            FU_SLL:  return a << b[4:0];
            FU_SRL:  return a >> b[4:0];
            default: return prod[`XLEN-1:0];
        endcase
    endfunction

    // ------------------------------
    // result compare
    // ------------------------------

    task automatic check_result();
        uop_t               u;
        logic [`XLEN-1:0]   exp;
        if (!pend[cdb.rob_id]) begin
            $display("a result for rob %0d came on the CDB but was never dispatched or came twice",
                     cdb.rob_id);
            err_count++;
        end else begin
            u = rec[cdb.rob_id];
            pend[cdb.rob_id] = 1'b0;
            outstanding--;
            exp = apply_op(u.op, model_val[u.rs1_phy], model_val[u.rs2_phy]);
            if (!model_known[u.rs1_phy] || !model_known[u.rs2_phy]) begin
                $display("%0s: rob %0d came out before the result it depends on",
                         rec_name[cdb.rob_id], cdb.rob_id);
                err_count++;
            end else if ((cdb.value !== exp) || (cdb.rd_phy !== u.rd_phy)) begin
                $display("** Error %0s: rob %0d expected rd %0d value %h, actual rd %0d value %h",
                         rec_name[cdb.rob_id], cdb.rob_id, u.rd_phy, exp, cdb.rd_phy, cdb.value);
                err_count++;
            end else begin
                $display("ok %0s: rob %0d rd %0d value %h",
                         rec_name[cdb.rob_id], cdb.rob_id, cdb.rd_phy, cdb.value);
                pass_count++;
            end
            model_val[u.rd_phy]   = exp;
            model_known[u.rd_phy] = 1'b1;
        end
    endtask

    task automatic record_uop();
        if (pend[in_uop.rob_id]) begin
            $display("rob %0d was dispatched again while still in flight", in_uop.rob_id);
            err_count++;
        end else begin
            outstanding++;
        end
        pend[in_uop.rob_id]     = 1'b1;
        rec[in_uop.rob_id]      = in_uop;
        rec_name[in_uop.rob_id] = test_name;
        // value unknown until its own result shows up
        model_known[in_uop.rd_phy] = 1'b0;
    endtask

    initial begin
        pass_count    = 0;
        err_count     = 0;
        outstanding   = 0;
        seen_reset    = 1'b0;
        reset_checked = 1'b0;
        saw_full      = 1'b0;
    end

    // ------------------------------
    // bus monitor
    // ------------------------------

    always @(posedge clk) begin
        if (rst) begin
            seen_reset    = 1'b1;
            reset_checked = 1'b0;
            outstanding   = 0;
            // a register is known only once it has been written
            for (int i = 0; i < `PRF_DEPTH; i++) begin
                model_val[i]   = '0;
                model_known[i] = 1'b0;
            end
            for (int r = 0; r < ROB_N; r++) begin
                pend[r] = 1'b0;
            end
        end else begin
            if (seen_reset && !reset_checked) begin
                reset_checked = 1'b1;
                if ((cdb_valid !== 1'b0) || (in_ready !== 1'b1)) begin
                    $display("after reset cdb_valid is %b and in_ready is %b, expected 0 and 1",
                             cdb_valid, in_ready);
                    err_count++;
                end
            end
            if (!in_ready) begin
                saw_full = 1'b1;
            end
            if (cdb_valid) begin
                check_result();
            end
            if (wb_valid) begin
                model_val[wb_phy]   = wb_value;
                model_known[wb_phy] = 1'b1;
            end
            if (in_valid && in_ready) begin
                record_uop();
            end
        end
    end

    // anything still pending at the end of the run is lost
    always @(posedge finish_run) begin
        for (int r = 0; r < ROB_N; r++) begin
            if (pend[r]) begin
                $display("%0s: the result for rob %0d never arrived", rec_name[r], r);
                err_count++;
            end
        end
        if (!saw_full) begin
            $display("in_ready never fell, so the lanes were never seen full");
            err_count++;
        end
        if (!reset_checked) begin
            $display("the state after reset was never checked");
            err_count++;
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_cluster.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module exec_cluster (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  uop_pkg::uop_t           in_uop,
    input  logic                    wb_valid,
    input  logic [`PRF_IDX-1:0]     wb_phy,
    input  logic [`XLEN-1:0]        wb_value,
    output logic                    in_ready,
    output logic                    cdb_valid,
    output cdb_pkg::cdb_t           cdb
);

    import uop_pkg::*;
    import cdb_pkg::*;

    localparam int CNT_W = $clog2(`RS_DEPTH + 1);

    // dispatch side
    logic [CNT_W-1:0]       free_count [`NUM_LANES];
    logic [`NUM_LANES-1:0]  push;
    uop_t                   push_uop;

    // snooped tags and register reads
    tag_t                   wake     [`CDB_WIDTH];
    logic [`PRF_IDX-1:0]    rd_phy   [`NUM_LANES][2];
    logic [`XLEN-1:0]       rd_value [`NUM_LANES][2];

    // queue to unit, unit to arbiter
    logic [`NUM_LANES-1:0]  iss_valid;
    logic [`NUM_LANES-1:0]  iss_ready;
    issue_t                 iss       [`NUM_LANES];
    logic [`NUM_LANES-1:0]  res_valid;
    logic [`NUM_LANES-1:0]  res_grant;
    cdb_t                   res       [`NUM_LANES];

    // ------------------------------
    // wakeup slots
    // ------------------------------

    assign wake[0].valid = cdb_valid;
    assign wake[0].phy   = cdb.rd_phy;
    assign wake[1].valid = wb_valid;
    assign wake[1].phy   = wb_phy;

    dispatch_router u_router (
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .free_count (free_count),
        .in_ready   (in_ready),
        .push       (push),
        .push_uop   (push_uop)
    );

    // ------------------------------
    // lanes
    // ------------------------------

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        issue_queue u_iq (
            .clk        (clk),
            .rst        (rst),
            .push       (push[g]),
            .push_uop   (push_uop),
            .wake       (wake),
            .rd_value1  (rd_value[g][0]),
            .rd_value2  (rd_value[g][1]),
            .iss_ready  (iss_ready[g]),
            .free_count (free_count[g]),
            .rd_phy1    (rd_phy[g][0]),
            .rd_phy2    (rd_phy[g][1]),
            .iss_valid  (iss_valid[g]),
            .iss        (iss[g])
        );

        int_fu u_fu (
            .clk        (clk),
            .rst        (rst),
            .iss_valid  (iss_valid[g]),
            .iss        (iss[g]),
            .res_grant  (res_grant[g]),
            .iss_ready  (iss_ready[g]),
            .res_valid  (res_valid[g]),
            .res        (res[g])
        );
    end

    phys_regfile u_prf (
        .clk        (clk),
        .rst        (rst),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb),
        .wb_valid   (wb_valid),
        .wb_phy     (wb_phy),
        .wb_value   (wb_value),
        .rd_phy     (rd_phy),
        .rd_value   (rd_value)
    );

    cdb_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res        (res),
        .res_grant  (res_grant),
        .cdb_valid  (cdb_valid),
        .cdb        (cdb)
    );

endmodule

`default_nettype wire

/* verilog/cdb_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module cdb_arbiter #(
    parameter int N_REQ = `NUM_LANES
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [N_REQ-1:0]    res_valid,
    input  cdb_pkg::cdb_t       res [N_REQ],
    output logic [N_REQ-1:0]    res_grant,
    output logic                cdb_valid,
    output cdb_pkg::cdb_t       cdb
);

    localparam int PTR_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

    logic [PTR_W-1:0]   ptr;
    logic [PTR_W-1:0]   win;

    // first requester at or after ptr, far end scanned first
    always_comb begin
        int idx;
        win = ptr;
        for (int i = N_REQ - 1; i >= 0; i--) begin
            idx = int'(ptr) + i;
            if (idx >= N_REQ) begin
                idx = idx - N_REQ;
            end
            if (res_valid[idx]) begin
                win = PTR_W'(idx);
            end
        end
    end

    assign cdb_valid = |res_valid;
    assign cdb       = res[win];

    always_comb begin
        res_grant = '0;
        if (cdb_valid) begin
            res_grant[win] = 1'b1;
        end
    end

    // pointer moves one past the last winner
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (cdb_valid) begin
            ptr <= (win == PTR_W'(N_REQ - 1)) ? '0 : PTR_W'(win + 1'b1);
        end
    end

endmodule

`default_nettype wire

/* verilog/phys_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module phys_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cdb_valid,
    input  cdb_pkg::cdb_t           cdb,
    input  logic                    wb_valid,
    input  logic [`PRF_IDX-1:0]     wb_phy,
    input  logic [`XLEN-1:0]        wb_value,
    input  logic [`PRF_IDX-1:0]     rd_phy   [`NUM_LANES][2],
    output logic [`XLEN-1:0]        rd_value [`NUM_LANES][2]
);

    logic [`XLEN-1:0] regs [`PRF_DEPTH];

    // ------------------------------
    // write ports
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PRF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_valid) begin
                regs[wb_phy] <= wb_value;
            end
            // cdb takes a same-register collision
            if (cdb_valid) begin
                regs[cdb.rd_phy] <= cdb.value;
            end
        end
    end

    // ------------------------------
    // read ports with bypass
    // ------------------------------

    // a tag woken this cycle needs the value that woke it
    always_comb begin
        for (int l = 0; l < `NUM_LANES; l++) begin
            for (int p = 0; p < 2; p++) begin
                if (cdb_valid && (cdb.rd_phy == rd_phy[l][p])) begin
                    rd_value[l][p] = cdb.value;
                end else if (wb_valid && (wb_phy == rd_phy[l][p])) begin
                    rd_value[l][p] = wb_value;
                end else begin
                    rd_value[l][p] = regs[rd_phy[l][p]];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/int_fu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module int_fu (
    input  logic                clk,
    input  logic                rst,
    input  logic                iss_valid,
    input  uop_pkg::issue_t     iss,
    input  logic                res_grant,
    output logic                iss_ready,
    output logic                res_valid,
    output cdb_pkg::cdb_t       res
);

    import uop_pkg::*;

    localparam int SH_W = $clog2(`XLEN);
    localparam int HALF = `XLEN / 2;

    // stage 2 payload, multiply still split in two partial products
    typedef struct packed {
        logic [`ROB_IDX-1:0]    rob_id;
        logic [`PRF_IDX-1:0]    rd_phy;
        logic                   is_mul;
        logic [`XLEN-1:0]       alu;
        logic [`XLEN-1:0]       pp_lo;
        logic [HALF-1:0]        pp_hi;
    } s2_t;

    logic       s1_valid;
    issue_t     s1;
    logic       s2_valid;
    s2_t        s2;
    s2_t        s2_in;
    logic       s2_free;

    // stage 2 frees up when empty or when its result goes out
    assign s2_free   = !s2_valid || res_grant;
    assign iss_ready = !s1_valid || s2_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (iss_ready) begin
                s1_valid <= iss_valid;
            end
            if (s2_free) begin
                s2_valid <= s1_valid;
            end
        end
    end

    // ------------------------------
    // stage 1
    // ------------------------------

    always_ff @(posedge clk) begin
        if (iss_valid && iss_ready) begin
            s1 <= iss;
        end
    end

    always_comb begin
        s2_in.rob_id = s1.rob_id;
        s2_in.rd_phy = s1.rd_phy;
        s2_in.is_mul = (s1.op == FU_MUL);
        case (s1.op)
            FU_ADD:  s2_in.alu = s1.a + s1.b;
            FU_SUB:  s2_in.alu = s1.a - s1.b;
            FU_AND:  s2_in.alu = s1.a & s1.b;
            FU_OR:   s2_in.alu = s1.a | s1.b;
            FU_XOR:  s2_in.alu = s1.a ^ s1.b;
            FU_SLL:  s2_in.alu = s1.a << s1.b[SH_W-1:0];
            FU_SRL:  s2_in.alu = s1.a >> s1.b[SH_W-1:0];
            default: s2_in.alu = '0;
        endcase
        // low word of a*b = a*b_lo + (a_lo*b_hi << HALF)
        s2_in.pp_lo = s1.a * {{HALF{1'b0}}, s1.b[HALF-1:0]};
        s2_in.pp_hi = s1.a[HALF-1:0] * s1.b[`XLEN-1:HALF];
    end

    // ------------------------------
    // stage 2, held until granted
    // ------------------------------

    always_ff @(posedge clk) begin
        if (s1_valid && s2_free) begin
            s2 <= s2_in;
        end
    end

    assign res_valid  = s2_valid;
    assign res.rob_id = s2.rob_id;
    assign res.rd_phy = s2.rd_phy;
    assign res.value  = s2.is_mul ? (s2.pp_lo + {s2.pp_hi, {HALF{1'b0}}}) : s2.alu;

endmodule

`default_nettype wire

/* verilog/issue_queue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module issue_queue #(
    parameter int DEPTH = `RS_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  uop_pkg::uop_t               push_uop,
    input  cdb_pkg::tag_t               wake [`CDB_WIDTH],
    input  logic [`XLEN-1:0]            rd_value1,
    input  logic [`XLEN-1:0]            rd_value2,
    input  logic                        iss_ready,
    output logic [$clog2(DEPTH+1)-1:0]  free_count,
    output logic [`PRF_IDX-1:0]         rd_phy1,
    output logic [`PRF_IDX-1:0]         rd_phy2,
    output logic                        iss_valid,
    output uop_pkg::issue_t             iss
);

    import uop_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entries below top are live, index 0 is the oldest
    uop_t               ent      [DEPTH];
    uop_t               ent_next [DEPTH];
    logic [CNT_W-1:0]   top;
    logic [CNT_W-1:0]   top_pop;
    logic [CNT_W-1:0]   top_next;

    logic [DEPTH-1:0]   src1_ok;
    logic [DEPTH-1:0]   src2_ok;
    uop_t               push_ent;

    logic               sel_en;
    logic [IDX_W-1:0]   sel_idx;
    logic               pop;

    // ------------------------------
    // wakeup
    // ------------------------------

    // stored ready bit or a matching tag this cycle
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            src1_ok[i] = ent[i].rs1_ready;
            src2_ok[i] = ent[i].rs2_ready;
            for (int k = 0; k < `CDB_WIDTH; k++) begin
                if (wake[k].valid && (wake[k].phy == ent[i].rs1_phy)) begin
                    src1_ok[i] = 1'b1;
                end
                if (wake[k].valid && (wake[k].phy == ent[i].rs2_phy)) begin
                    src2_ok[i] = 1'b1;
                end
            end
        end
    end

    // a producer may broadcast in the very cycle its consumer is pushed
    always_comb begin
        push_ent = push_uop;
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (wake[k].valid && (wake[k].phy == push_uop.rs1_phy)) begin
                push_ent.rs1_ready = 1'b1;
            end
            if (wake[k].valid && (wake[k].phy == push_uop.rs2_phy)) begin
                push_ent.rs2_ready = 1'b1;
            end
        end
    end

    // ------------------------------
    // select, oldest ready first
    // ------------------------------

    // scanning downward leaves the lowest match
    always_comb begin
        sel_en  = 1'b0;
        sel_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if ((CNT_W'(i) < top) && src1_ok[i] && src2_ok[i]) begin
                sel_en  = 1'b1;
                sel_idx = IDX_W'(i);
            end
        end
    end

    assign pop      = sel_en && iss_ready;
    assign top_pop  = top - CNT_W'(pop);
    assign top_next = top_pop + CNT_W'(push);

    // ------------------------------
    // compaction and push
    // ------------------------------

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ent_next[i]           = ent[i];
            ent_next[i].rs1_ready = src1_ok[i];
            ent_next[i].rs2_ready = src2_ok[i];
        end
        // younger entries slide down over the issued slot
        for (int i = 0; i < DEPTH - 1; i++) begin
            if (pop && (IDX_W'(i) >= sel_idx)) begin
                ent_next[i]           = ent[i + 1];
                ent_next[i].rs1_ready = src1_ok[i + 1];
                ent_next[i].rs2_ready = src2_ok[i + 1];
            end
        end
        // push lands on the top left after the pop
        for (int i = 0; i < DEPTH; i++) begin
            if (push && (CNT_W'(i) == top_pop)) begin
                ent_next[i] = push_ent;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            top <= '0;
        end else begin
            top <= top_next;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            ent[i] <= ent_next[i];
        end
    end

    // ------------------------------
    // operand read and issue
    // ------------------------------

    assign rd_phy1    = ent[sel_idx].rs1_phy;
    assign rd_phy2    = ent[sel_idx].rs2_phy;
    assign free_count = CNT_W'(DEPTH) - top;
    assign iss_valid  = sel_en;

    always_comb begin
        iss.rob_id = ent[sel_idx].rob_id;
        iss.rd_phy = ent[sel_idx].rd_phy;
        iss.op     = ent[sel_idx].op;
        iss.a      = rd_value1;
        iss.b      = rd_value2;
    end

endmodule

`default_nettype wire

/* verilog/dispatch_router.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ooo_defs.svh"

module dispatch_router (
    input  logic                            in_valid,
    input  uop_pkg::uop_t                   in_uop,
    input  logic [$clog2(`RS_DEPTH+1)-1:0]  free_count [`NUM_LANES],
    output logic                            in_ready,
    output logic [`NUM_LANES-1:0]           push,
    output uop_pkg::uop_t                   push_uop
);

    localparam int CNT_W  = $clog2(`RS_DEPTH + 1);
    localparam int LANE_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;

    logic [LANE_W-1:0]  best;
    logic [CNT_W-1:0]   best_cnt;

    // ------------------------------
    // lane choice
    // ------------------------------

    // strict compare keeps the lowest lane on a tie
    always_comb begin
        best     = '0;
        best_cnt = free_count[0];
        for (int i = 1; i < `NUM_LANES; i++) begin
            if (free_count[i] > best_cnt) begin
                best     = LANE_W'(i);
                best_cnt = free_count[i];
            end
        end
    end

    // the emptiest lane has room iff any lane has room
    assign in_ready = (best_cnt != '0);

    // ------------------------------
    // push strobe
    // ------------------------------

    always_comb begin
        push = '0;
        if (in_valid && in_ready) begin
            push[best] = 1'b1;
        end
    end

    // every lane sees the same micro-op, only the strobe differs
    assign push_uop = in_uop;

endmodule

`default_nettype wire

/* verilog/cdb_pkg.sv */
`default_nettype none

`include "ooo_defs.svh"

package cdb_pkg;

    // register tag seen by the snooping queues
    typedef struct packed {
        logic                   valid;
        logic [`PRF_IDX-1:0]    phy;
    } tag_t;

    // one result on the common data bus
    typedef struct packed {
        logic [`ROB_IDX-1:0]    rob_id;
        logic [`PRF_IDX-1:0]    rd_phy;
        logic [`XLEN-1:0]       value;
    } cdb_t;

endpackage

`default_nettype wire

/* verilog/uop_pkg.sv */
`default_nettype none

`include "ooo_defs.svh"

package uop_pkg;

    typedef enum logic [2:0] {
        FU_ADD = 3'd0,
        FU_SUB = 3'd1,
        FU_AND = 3'd2,
        FU_OR  = 3'd3,
        FU_XOR = 3'd4,
        FU_SLL = 3'd5,
        FU_SRL = 3'd6,
        FU_MUL = 3'd7
    } fu_op_e;

    // renamed micro-op as it arrives from dispatch
    typedef struct packed {
        logic [`ROB_IDX-1:0]    rob_id;
        logic [`PRF_IDX-1:0]    rs1_phy;
        logic                   rs1_ready;
        logic [`PRF_IDX-1:0]    rs2_phy;
        logic                   rs2_ready;
        logic [`PRF_IDX-1:0]    rd_phy;
        fu_op_e                 op;
    } uop_t;

    // micro-op leaving a queue with its operands read
    typedef struct packed {
        logic [`ROB_IDX-1:0]    rob_id;
        logic [`PRF_IDX-1:0]    rd_phy;
        fu_op_e                 op;
        logic [`XLEN-1:0]       a;
        logic [`XLEN-1:0]       b;
    } issue_t;

endpackage

`default_nettype wire

/* verilog/ooo_defs.svh */
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// datapath width
`define XLEN        32

// physical register file
`define PRF_DEPTH   64
`define PRF_IDX     6

// reorder tag width
`define ROB_IDX     5

// reservation station entries per lane
`define RS_DEPTH    4
`define NUM_LANES   2

// slot 0 internal cdb, slot 1 external writeback
`define CDB_WIDTH   2

`endif
